//--- source/port_c_pkg.sv
/* Port C controller shared definitions: port width, pin roles,
   direction and mode encodings and the decoded command opcodes */
package port_c_pkg;

    localparam int PORT_WIDTH = 8;

    typedef enum logic {
        DIR_OUTPUT = 1'b0,
        DIR_INPUT  = 1'b1
    } dir_t;

    typedef enum logic {
        MODE_0 = 1'b0,
        MODE_1 = 1'b1
    } mode_t;

    // Listed from highest to lowest priority
    typedef enum logic [2:0] {
        CMD_BIT_SET   = 3'd0,
        CMD_WRITE_C   = 3'd1,
        CMD_MODE_A    = 3'd2,
        CMD_MODE_B    = 3'd3,
        CMD_MODE_BOTH = 3'd4,
        CMD_NONE      = 3'd5
    } cmd_op_t;

    // Group B roles, lower half
    localparam logic [2:0] PIN_INTR_B    = 3'd0;
    localparam logic [2:0] PIN_BUF_B     = 3'd1;
    localparam logic [2:0] PIN_STB_ACK_B = 3'd2;

    // Group A roles, pin 3 and the upper half
    localparam logic [2:0] PIN_INTR_A    = 3'd3;
    localparam logic [2:0] PIN_STB_A     = 3'd4;
    localparam logic [2:0] PIN_IBF_A     = 3'd5;
    localparam logic [2:0] PIN_ACK_A     = 3'd6;
    localparam logic [2:0] PIN_OBF_A     = 3'd7;

endpackage

//--- source/port_c_cmd_if.sv
/* Decoded port C command, valid in the cycle its opcode is not CMD_NONE */
`timescale 1ns/1ps

interface port_c_cmd_if import port_c_pkg::*; ();

    cmd_op_t                 op;
    logic [2:0]              bit_index;
    logic                    bit_value;
    logic [PORT_WIDTH-1:0]   data;
    mode_t                   new_mode_a;
    mode_t                   new_mode_b;
    dir_t                    new_dir_a;
    dir_t                    new_dir_b;

    modport decode (
        output op, bit_index, bit_value, data,
        output new_mode_a, new_mode_b, new_dir_a, new_dir_b
    );

    modport registers (
        input op, bit_index, bit_value, data,
        input new_mode_a, new_mode_b, new_dir_a, new_dir_b
    );

endinterface

//--- source/port_c_group_if.sv
/* Link between one handshake group engine and the port C registers */
`timescale 1ns/1ps

interface port_c_group_if ();

    // Pin inputs after direction gating, output pins read as 1
    logic stb_n;
    logic ack_n;
    logic inte;

    // Current status bits held in port C
    logic intr_q;
    logic ibf_q;
    logic obf_n_q;

    // Next status from the engine
    logic intr_next;
    logic ibf_next;
    logic obf_n_next;

    modport engine (
        input  stb_n, ack_n, inte, intr_q, ibf_q, obf_n_q,
        output intr_next, ibf_next, obf_n_next
    );

    modport registers (
        output stb_n, ack_n, inte, intr_q, ibf_q, obf_n_q,
        input  intr_next, ibf_next, obf_n_next
    );

endinterface

//--- source/port_c_command_decode.sv
/* Port C command decode: bus strobes to one prioritized command,
   plus begin and end events of the port A and port B reads */
`timescale 1ns/1ps

module port_c_command_decode import port_c_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [PORT_WIDTH-1:0]   bus_data,
    input  logic                    write_port_c,
    input  logic                    write_port_c_bit_set,
    input  logic                    update_group_a_mode,
    input  logic                    update_group_b_mode,
    input  logic                    read_port_a,
    input  logic                    read_port_b,
    port_c_cmd_if.decode            cmd,
    output logic                    read_begin_a,
    output logic                    read_end_a,
    output logic                    read_begin_b,
    output logic                    read_end_b
);

    logic read_port_a_q;
    logic read_port_b_q;

    always_comb begin
        if (write_port_c_bit_set)
            cmd.op = CMD_BIT_SET;
        else if (write_port_c)
            cmd.op = CMD_WRITE_C;
        else if (update_group_a_mode && update_group_b_mode)
            cmd.op = CMD_MODE_BOTH;
        else if (update_group_a_mode)
            cmd.op = CMD_MODE_A;
        else if (update_group_b_mode)
            cmd.op = CMD_MODE_B;
        else
            cmd.op = CMD_NONE;
    end

    // Bit set/reset byte: index in [3:1], value in [0]
    assign cmd.bit_index  = bus_data[3:1];
    assign cmd.bit_value  = bus_data[0];
    assign cmd.data       = bus_data;

    // Mode byte, bit 6 unused without mode 2
    assign cmd.new_mode_a = mode_t'(bus_data[5]);
    assign cmd.new_dir_a  = dir_t'(bus_data[4]);
    assign cmd.new_mode_b = mode_t'(bus_data[2]);
    assign cmd.new_dir_b  = dir_t'(bus_data[1]);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            read_port_a_q <= 1'b0;
            read_port_b_q <= 1'b0;
        end else begin
            read_port_a_q <= read_port_a;
            read_port_b_q <= read_port_b;
        end
    end

    assign read_begin_a = read_port_a & ~read_port_a_q;
    assign read_end_a   = ~read_port_a & read_port_a_q;
    assign read_begin_b = read_port_b & ~read_port_b_q;
    assign read_end_b   = ~read_port_b & read_port_b_q;

endmodule

//--- source/port_c_handshake_group.sv
/* Mode 1 handshake engine for one group: next IBF, /OBF and INTR
   from the strobe, acknowledge and read/write events */
`timescale 1ns/1ps

module port_c_handshake_group import port_c_pkg::*; #(
    parameter int STB_PIN      = 4,
    parameter int ACK_PIN      = 6,
    parameter int IBF_PIN      = 5,
    parameter int OBF_PIN      = 7,
    parameter int INTR_PIN     = 3,
    parameter int INTE_IN_PIN  = 4,
    parameter int INTE_OUT_PIN = 6
) (
    input  dir_t                port_dir,
    input  logic                write_port,
    input  logic                read_begin,
    input  logic                read_end,
    port_c_group_if.engine      grp,
    output logic                strobe
);

    logic ibf_next;
    logic obf_n_next;
    logic intr_next;

    // Pin map sanity, INTR needs a pin of its own
    if (INTR_PIN == STB_PIN || INTR_PIN == ACK_PIN ||
        INTR_PIN == IBF_PIN || INTR_PIN == OBF_PIN) begin : g_intr_pin_check
        $error("INTR pin %0d overlaps a handshake pin", INTR_PIN);
    end

    // INTE lives on the strobe pin for input, the acknowledge pin for output
    if (INTE_IN_PIN != STB_PIN || INTE_OUT_PIN != ACK_PIN) begin : g_inte_pin_check
        $error("INTE pins %0d/%0d do not match STB/ACK", INTE_IN_PIN, INTE_OUT_PIN);
    end

    // Input buffer full
    always_comb begin
        ibf_next = grp.ibf_q;
        if (!grp.stb_n)
            ibf_next = 1'b1;
        if (read_end)
            ibf_next = 1'b0;
    end

    // Output buffer full, active low
    always_comb begin
        obf_n_next = grp.obf_n_q;
        if (write_port)
            obf_n_next = 1'b0;
        if (!grp.ack_n)
            obf_n_next = 1'b1;
    end

    always_comb begin
        intr_next = grp.intr_q;
        if (port_dir == DIR_INPUT) begin
            if (grp.stb_n && ibf_next)
                intr_next = 1'b1;
            if (read_begin)
                intr_next = 1'b0;
        end else begin
            if (grp.ack_n && obf_n_next)
                intr_next = 1'b1;
            if (write_port)
                intr_next = 1'b0;
        end
        if (!grp.inte)
            intr_next = 1'b0;
    end

    assign grp.ibf_next   = ibf_next;
    assign grp.obf_n_next = obf_n_next;
    assign grp.intr_next  = intr_next;

    assign strobe = ~grp.stb_n;

endmodule

//--- source/port_c_registers.sv
/* Port C output, direction and read-back registers, with command
   priority over mode updates and the mode 1 group status */
`timescale 1ns/1ps

module port_c_registers import port_c_pkg::*; #(
    parameter int A_INTR_PIN    = PIN_INTR_A,
    parameter int A_STB_PIN     = PIN_STB_A,
    parameter int A_IBF_PIN     = PIN_IBF_A,
    parameter int A_ACK_PIN     = PIN_ACK_A,
    parameter int A_OBF_PIN     = PIN_OBF_A,
    parameter int B_INTR_PIN    = PIN_INTR_B,
    parameter int B_BUF_PIN     = PIN_BUF_B,
    parameter int B_STB_ACK_PIN = PIN_STB_ACK_B
) (
    input  logic                    clock,
    input  logic                    reset,
    port_c_cmd_if.registers         cmd,
    port_c_group_if.registers       group_a,
    port_c_group_if.registers       group_b,
    input  mode_t                   mode_a,
    input  mode_t                   mode_b,
    input  dir_t                    port_a_dir,
    input  dir_t                    port_b_dir,
    input  dir_t                    port_c_upper_dir,
    input  dir_t                    port_c_lower_dir,
    input  logic [PORT_WIDTH-1:0]   port_c_in,
    output logic [PORT_WIDTH-1:0]   port_c_out,
    output logic [PORT_WIDTH-1:0]   port_c_dir,
    output logic [PORT_WIDTH-1:0]   port_c_read
);

    localparam int HALF = PORT_WIDTH / 2;

    // Bits cleared when a group's mode is rewritten
    localparam logic [PORT_WIDTH-1:0] GROUP_A_MASK =
        (PORT_WIDTH'(1) << A_INTR_PIN) | (PORT_WIDTH'(1) << A_STB_PIN) |
        (PORT_WIDTH'(1) << A_IBF_PIN)  | (PORT_WIDTH'(1) << A_ACK_PIN) |
        (PORT_WIDTH'(1) << A_OBF_PIN);
    localparam logic [PORT_WIDTH-1:0] GROUP_B_MASK =
        (PORT_WIDTH'(1) << B_INTR_PIN) | (PORT_WIDTH'(1) << B_BUF_PIN) |
        (PORT_WIDTH'(1) << B_STB_ACK_PIN);

    logic                  update_a;
    logic                  update_b;
    logic [PORT_WIDTH-1:0] out_next;
    logic [PORT_WIDTH-1:0] dir_next;
    logic [PORT_WIDTH-1:0] read_next;

    assign update_a = (cmd.op == CMD_MODE_A) || (cmd.op == CMD_MODE_BOTH);
    assign update_b = (cmd.op == CMD_MODE_B) || (cmd.op == CMD_MODE_BOTH);

    // Handshake inputs, output pins read as inactive
    assign group_a.stb_n = (port_c_dir[A_STB_PIN] == DIR_INPUT) ? port_c_in[A_STB_PIN] : 1'b1;
    assign group_a.ack_n = (port_c_dir[A_ACK_PIN] == DIR_INPUT) ? port_c_in[A_ACK_PIN] : 1'b1;
    assign group_a.inte  = (port_a_dir == DIR_INPUT) ? port_c_out[A_STB_PIN]
                                                     : port_c_out[A_ACK_PIN];
    assign group_a.intr_q  = port_c_out[A_INTR_PIN];
    assign group_a.ibf_q   = port_c_out[A_IBF_PIN];
    assign group_a.obf_n_q = port_c_out[A_OBF_PIN];

    // Group B shares one pin for STB/ACK and one for IBF/OBF
    assign group_b.stb_n = (port_c_dir[B_STB_ACK_PIN] == DIR_INPUT) ?
                           port_c_in[B_STB_ACK_PIN] : 1'b1;
    assign group_b.ack_n   = group_b.stb_n;
    assign group_b.inte    = port_c_out[B_STB_ACK_PIN];
    assign group_b.intr_q  = port_c_out[B_INTR_PIN];
    assign group_b.ibf_q   = port_c_out[B_BUF_PIN];
    assign group_b.obf_n_q = port_c_out[B_BUF_PIN];

    // Lowest priority first, later assignments win
    always_comb begin
        out_next = port_c_out;

        if (mode_a == MODE_1) begin
            out_next[A_INTR_PIN] = group_a.intr_next;
            if (port_a_dir == DIR_INPUT)
                out_next[A_IBF_PIN] = group_a.ibf_next;
            else
                out_next[A_OBF_PIN] = group_a.obf_n_next;
        end
        if (mode_b == MODE_1) begin
            out_next[B_INTR_PIN] = group_b.intr_next;
            out_next[B_BUF_PIN]  = (port_b_dir == DIR_INPUT) ? group_b.ibf_next
                                                             : group_b.obf_n_next;
        end

        if (update_a) begin
            out_next = out_next & ~GROUP_A_MASK;
            if (cmd.new_mode_a == MODE_1 && cmd.new_dir_a == DIR_OUTPUT)
                out_next[A_OBF_PIN] = 1'b1;
        end
        if (update_b) begin
            out_next = out_next & ~GROUP_B_MASK;
            if (cmd.new_mode_b == MODE_1 && cmd.new_dir_b == DIR_OUTPUT)
                out_next[B_BUF_PIN] = 1'b1;
        end

        if (cmd.op == CMD_WRITE_C)
            out_next = cmd.data;
        if (cmd.op == CMD_BIT_SET)
            out_next[cmd.bit_index] = cmd.bit_value;
    end

    // Direction per pin from the group modes
    always_comb begin
        dir_next = {PORT_WIDTH{DIR_INPUT}};

        if (port_c_lower_dir == DIR_OUTPUT)
            dir_next[HALF-1:0] = {HALF{DIR_OUTPUT}};
        if (mode_b == MODE_1) begin
            dir_next[B_INTR_PIN]    = DIR_OUTPUT;
            dir_next[B_BUF_PIN]     = DIR_OUTPUT;
            dir_next[B_STB_ACK_PIN] = DIR_INPUT;
        end

        if (port_c_upper_dir == DIR_OUTPUT)
            dir_next[PORT_WIDTH-1:HALF] = {HALF{DIR_OUTPUT}};
        if (mode_a == MODE_1) begin
            dir_next[A_INTR_PIN] = DIR_OUTPUT;
            if (port_a_dir == DIR_INPUT) begin
                dir_next[A_STB_PIN] = DIR_INPUT;
                dir_next[A_IBF_PIN] = DIR_OUTPUT;
            end else begin
                dir_next[A_ACK_PIN] = DIR_INPUT;
                dir_next[A_OBF_PIN] = DIR_OUTPUT;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < PORT_WIDTH; i++)
            read_next[i] = (port_c_dir[i] == DIR_OUTPUT) ? port_c_out[i] : port_c_in[i];
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            port_c_out  <= '0;
            port_c_dir  <= {PORT_WIDTH{DIR_INPUT}};
            port_c_read <= '0;
        end else begin
            port_c_out  <= out_next;
            port_c_dir  <= dir_next;
            port_c_read <= read_next;
            // Half being reconfigured reads as zero
            if (update_a)
                port_c_read[PORT_WIDTH-1:HALF] <= '0;
            if (update_b)
                port_c_read[HALF-1:0] <= '0;
        end
    end

endmodule

//--- source/port_c_top.sv
/* 8255-style port C controller: mode 0 I/O and the mode 1
   handshake lines for groups A and B */
`timescale 1ns/1ps

module port_c_top import port_c_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [PORT_WIDTH-1:0]   bus_data,
    input  logic                    write_port_a,
    input  logic                    write_port_b,
    input  logic                    write_port_c,
    input  logic                    write_port_c_bit_set,
    input  logic                    read_port_a,
    input  logic                    read_port_b,
    input  logic                    update_group_a_mode,
    input  logic                    update_group_b_mode,
    input  logic                    group_a_mode,
    input  logic                    group_b_mode,
    input  logic                    port_a_dir,
    input  logic                    port_b_dir,
    input  logic                    port_c_upper_dir,
    input  logic                    port_c_lower_dir,
    input  logic [PORT_WIDTH-1:0]   port_c_in,
    output logic [PORT_WIDTH-1:0]   port_c_out,
    output logic [PORT_WIDTH-1:0]   port_c_dir,
    output logic [PORT_WIDTH-1:0]   port_c_read,
    output logic                    port_a_strobe,
    output logic                    port_b_strobe
);

    logic read_begin_a;
    logic read_end_a;
    logic read_begin_b;
    logic read_end_b;

    port_c_cmd_if   cmd_bus ();
    port_c_group_if group_a_bus ();
    port_c_group_if group_b_bus ();

    port_c_command_decode decode_i (
        .clock                (clock),
        .reset                (reset),
        .bus_data             (bus_data),
        .write_port_c         (write_port_c),
        .write_port_c_bit_set (write_port_c_bit_set),
        .update_group_a_mode  (update_group_a_mode),
        .update_group_b_mode  (update_group_b_mode),
        .read_port_a          (read_port_a),
        .read_port_b          (read_port_b),
        .cmd                  (cmd_bus.decode),
        .read_begin_a         (read_begin_a),
        .read_end_a           (read_end_a),
        .read_begin_b         (read_begin_b),
        .read_end_b           (read_end_b)
    );

    port_c_handshake_group #(
        .STB_PIN      (PIN_STB_A),
        .ACK_PIN      (PIN_ACK_A),
        .IBF_PIN      (PIN_IBF_A),
        .OBF_PIN      (PIN_OBF_A),
        .INTR_PIN     (PIN_INTR_A),
        .INTE_IN_PIN  (PIN_STB_A),
        .INTE_OUT_PIN (PIN_ACK_A)
    ) group_a_i (
        .port_dir   (dir_t'(port_a_dir)),
        .write_port (write_port_a),
        .read_begin (read_begin_a),
        .read_end   (read_end_a),
        .grp        (group_a_bus.engine),
        .strobe     (port_a_strobe)
    );

    // Group B carries STB/ACK and IBF/OBF on shared pins
    port_c_handshake_group #(
        .STB_PIN      (PIN_STB_ACK_B),
        .ACK_PIN      (PIN_STB_ACK_B),
        .IBF_PIN      (PIN_BUF_B),
        .OBF_PIN      (PIN_BUF_B),
        .INTR_PIN     (PIN_INTR_B),
        .INTE_IN_PIN  (PIN_STB_ACK_B),
        .INTE_OUT_PIN (PIN_STB_ACK_B)
    ) group_b_i (
        .port_dir   (dir_t'(port_b_dir)),
        .write_port (write_port_b),
        .read_begin (read_begin_b),
        .read_end   (read_end_b),
        .grp        (group_b_bus.engine),
        .strobe     (port_b_strobe)
    );

    port_c_registers #(
        .A_INTR_PIN    (PIN_INTR_A),
        .A_STB_PIN     (PIN_STB_A),
        .A_IBF_PIN     (PIN_IBF_A),
        .A_ACK_PIN     (PIN_ACK_A),
        .A_OBF_PIN     (PIN_OBF_A),
        .B_INTR_PIN    (PIN_INTR_B),
        .B_BUF_PIN     (PIN_BUF_B),
        .B_STB_ACK_PIN (PIN_STB_ACK_B)
    ) registers_i (
        .clock            (clock),
        .reset            (reset),
        .cmd              (cmd_bus.registers),
        .group_a          (group_a_bus.registers),
        .group_b          (group_b_bus.registers),
        .mode_a           (mode_t'(group_a_mode)),
        .mode_b           (mode_t'(group_b_mode)),
        .port_a_dir       (dir_t'(port_a_dir)),
        .port_b_dir       (dir_t'(port_b_dir)),
        .port_c_upper_dir (dir_t'(port_c_upper_dir)),
        .port_c_lower_dir (dir_t'(port_c_lower_dir)),
        .port_c_in        (port_c_in),
        .port_c_out       (port_c_out),
        .port_c_dir       (port_c_dir),
        .port_c_read      (port_c_read)
    );

endmodule

//--- dv/port_c_checker.sv
/* Port C controller assertions: reset direction, bit set result
   and the port A strobe gating */
`timescale 1ns/1ps

module port_c_checker import port_c_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [PORT_WIDTH-1:0]   bus_data,
    input  logic                    write_port_c_bit_set,
    input  logic [PORT_WIDTH-1:0]   port_c_out,
    input  logic [PORT_WIDTH-1:0]   port_c_dir,
    input  logic                    port_a_strobe
);

    // Direction register comes out of reset as all inputs
    dir_after_reset: assert property (
        @(posedge clock) reset |=> (port_c_dir == {PORT_WIDTH{1'b1}})
    ) else $error("port_c_dir is not all input after reset");

    // Bit set has top priority, so the addressed bit always lands
    bit_set_applied: assert property (
        @(posedge clock) disable iff (reset)
        write_port_c_bit_set |=> (port_c_out[$past(bus_data[3:1])] == $past(bus_data[0]))
    ) else $error("bit set command did not update the addressed bit");

    strobe_needs_input: assert property (
        @(posedge clock) disable iff (reset)
        port_a_strobe |-> (port_c_dir[PIN_STB_A] == DIR_INPUT)
    ) else $error("port_a_strobe high while pin %0d is an output", PIN_STB_A);

endmodule

//--- dv/port_c_tb.sv
/* Port C controller testbench: golden vectors drive the bus and pins,
   outputs are compared once each vector has settled */
`timescale 1ns/1ps

module port_c_tb import port_c_pkg::*; ();

    logic                    clock;
    logic                    reset;
    logic [PORT_WIDTH-1:0]   bus_data;
    logic                    write_port_a;
    logic                    write_port_b;
    logic                    write_port_c;
    logic                    write_port_c_bit_set;
    logic                    read_port_a;
    logic                    read_port_b;
    logic                    update_group_a_mode;
    logic                    update_group_b_mode;
    logic                    group_a_mode;
    logic                    group_b_mode;
    logic                    port_a_dir;
    logic                    port_b_dir;
    logic                    port_c_upper_dir;
    logic                    port_c_lower_dir;
    logic [PORT_WIDTH-1:0]   port_c_in;
    logic [PORT_WIDTH-1:0]   port_c_out;
    logic [PORT_WIDTH-1:0]   port_c_dir;
    logic [PORT_WIDTH-1:0]   port_c_read;
    logic                    port_a_strobe;
    logic                    port_b_strobe;

    // One entry per golden line
    int         vec_test[$];
    int         vec_edges[$];
    logic [7:0] vec_op[$];
    logic [7:0] vec_bus[$];
    logic [5:0] vec_cfg[$];
    logic [7:0] vec_in[$];
    logic [7:0] vec_out[$];
    logic [7:0] vec_dir[$];
    logic [7:0] vec_read[$];
    logic [1:0] vec_strb[$];

    int error_count = 0;
    int test_errors = 0;
    int test_vectors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    port_c_top dut_i (.*);

    bind port_c_top port_c_checker checker_i (
        .clock                (clock),
        .reset                (reset),
        .bus_data             (bus_data),
        .write_port_c_bit_set (write_port_c_bit_set),
        .port_c_out           (port_c_out),
        .port_c_dir           (port_c_dir),
        .port_a_strobe        (port_a_strobe)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Run timed out after %0d cycles", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic string test_name(int id);
        case (id)
            1: return "mode 0 output";
            2: return "bit set and reset";
            3: return "mode 0 input";
            4: return "group B mode 1 input";
            5: return "group A mode 1 output";
            6: return "mode update masking";
            default: return "unknown";
        endcase
    endfunction

    task automatic load_vectors();
        int         fd;
        int         count;
        string      line;
        int         t;
        int         e;
        logic [7:0] op, bus, pins, out, dir, rd;
        logic [5:0] cfg;
        logic [1:0] strb;
        fd = $fopen("dv/port_c_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open dv/port_c_golden.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#")
                continue;
            count = $sscanf(line, "%d %d %h %h %h %h %h %h %h %h",
                            t, e, op, bus, cfg, pins, out, dir, rd, strb);
            if (count == 10) begin
                vec_test.push_back(t);
                vec_edges.push_back(e);
                vec_op.push_back(op);
                vec_bus.push_back(bus);
                vec_cfg.push_back(cfg);
                vec_in.push_back(pins);
                vec_out.push_back(out);
                vec_dir.push_back(dir);
                vec_read.push_back(rd);
                vec_strb.push_back(strb);
            end
        end
        $fclose(fd);
    endtask

    // Read strobes are levels held for the whole vector
    task automatic drive_vector(int i);
        logic [7:0] op;
        logic [5:0] cfg;
        op  = vec_op[i];
        cfg = vec_cfg[i];
        bus_data             = vec_bus[i];
        write_port_a         = op[0];
        write_port_b         = op[1];
        write_port_c         = op[2];
        write_port_c_bit_set = op[3];
        read_port_a          = op[4];
        read_port_b          = op[5];
        update_group_a_mode  = op[6];
        update_group_b_mode  = op[7];
        group_a_mode         = cfg[5];
        group_b_mode         = cfg[4];
        port_a_dir           = cfg[3];
        port_b_dir           = cfg[2];
        port_c_upper_dir     = cfg[1];
        port_c_lower_dir     = cfg[0];
        port_c_in            = vec_in[i];
    endtask

    task automatic release_strobes();
        write_port_a         = 1'b0;
        write_port_b         = 1'b0;
        write_port_c         = 1'b0;
        write_port_c_bit_set = 1'b0;
        update_group_a_mode  = 1'b0;
        update_group_b_mode  = 1'b0;
    endtask

    task automatic count_error();
        error_count++;
        test_errors++;
    endtask

    task automatic check_outputs(int i);
        logic [1:0] strobes;
        strobes = {port_a_strobe, port_b_strobe};
        test_vectors++;
        if (port_c_out !== vec_out[i]) begin
            $display("Error at %0t: vector %0d port_c_out expected %h, got %h",
                     $time, i + 1, vec_out[i], port_c_out);
            count_error();
        end
        if (port_c_dir !== vec_dir[i]) begin
            $display("Error at %0t: vector %0d port_c_dir expected %h, got %h",
                     $time, i + 1, vec_dir[i], port_c_dir);
            count_error();
        end
        if (port_c_read !== vec_read[i]) begin
            $display("Error at %0t: vector %0d port_c_read expected %h, got %h",
                     $time, i + 1, vec_read[i], port_c_read);
            count_error();
        end
        if (strobes !== vec_strb[i]) begin
            $display("Error at %0t: vector %0d strobes A/B expected %b, got %b",
                     $time, i + 1, vec_strb[i], strobes);
            count_error();
        end
    endtask

    task automatic report_test(int id);
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %0d, %s: %0d vectors ok", id, test_name(id), test_vectors);
        end else begin
            tests_failed++;
            $display("Test %0d, %s: %0d vectors, %0d errors",
                     id, test_name(id), test_vectors, test_errors);
        end
        test_errors  = 0;
        test_vectors = 0;
    endtask

    initial begin
        int i;
        int e;
        clock = 1'b0;
        reset = 1'b1;
        bus_data = '0;
        release_strobes();
        read_port_a      = 1'b0;
        read_port_b      = 1'b0;
        group_a_mode     = 1'b0;
        group_b_mode     = 1'b0;
        port_a_dir       = 1'b1;
        port_b_dir       = 1'b1;
        port_c_upper_dir = 1'b1;
        port_c_lower_dir = 1'b1;
        port_c_in        = '1;
        load_vectors();
        if (vec_test.size() == 0) begin
            $display("No vectors could be read from the golden file");
            $display("SOME TESTS FAILED");
        end else begin
            cycle_limit = vec_test.size() * 6 + 100;
            repeat (16) @(posedge clock);
            @(negedge clock);
            reset = 1'b0;
            @(negedge clock);
            for (i = 0; i < vec_test.size(); i++) begin
                if (i > 0 && vec_test[i] != vec_test[i-1])
                    report_test(vec_test[i-1]);
                drive_vector(i);
                for (e = 0; e < vec_edges[i]; e++) begin
                    @(posedge clock);
                    @(negedge clock);
                    if (e == 0)
                        release_strobes();
                end
                check_outputs(i);
            end
            report_test(vec_test[vec_test.size()-1]);
            $display("Tests %0d, failed %0d, vectors %0d, errors %0d",
                     tests_run, tests_failed, vec_test.size(), error_count);
            if (error_count == 0)
                $display("ALL TESTS PASSED");
            else
                $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- port_c.f
source/port_c_pkg.sv
source/port_c_cmd_if.sv
source/port_c_group_if.sv
source/port_c_command_decode.sv
source/port_c_handshake_group.sv
source/port_c_registers.sv
source/port_c_top.sv
dv/port_c_checker.sv
dv/port_c_tb.sv

//--- Makefile
sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f port_c.f --top-module port_c_tb -Mdir obj_dir
	./obj_dir/Vport_c_tb | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- dv/port_c_golden.txt
# Columns: test, edges to wait, then hex: op, bus_data, cfg, port_c_in, out, dir, read, strobes
# op bits 0..7: wr_a wr_b wr_c bit_set rd_a rd_b upd_a upd_b; cfg 5..0: mode_a mode_b a_dir b_dir upper lower
# Mode 0 output, whole byte write
1 3 04 A5 0C 00 A5 00 A5 0
# Bit set and reset on the byte in place
2 3 08 03 0C 5A A7 00 A7 0
2 3 08 0E 0C 5A 27 00 27 0
2 3 08 00 0C 5A 26 00 26 0
2 3 08 09 0C 5A 36 00 36 0
2 3 08 0B 0C 5A 36 00 36 0
2 3 08 04 0C 5A 32 00 32 0
# Mode 0 input
3 3 00 00 0F 3C 32 FF 3C 0
3 3 00 00 0F 96 32 FF 96 0
# Group B mode 1 input: update, INTE, strobe low, release, read begin, read end
4 3 80 06 1F 54 30 FC 54 0
4 3 08 05 1F 54 34 FC 54 0
4 3 00 00 1F 50 36 FC 52 1
4 3 00 00 1F 54 37 FC 57 0
4 1 20 00 1F 54 36 FC 57 0
4 3 00 00 1F 54 34 FC 54 0
# Group A mode 1 output: update, write, ACK low, INTE, write again
5 3 40 20 37 54 84 74 D4 0
5 3 01 00 37 54 04 74 54 0
5 3 00 00 37 14 84 74 94 0
5 3 08 0D 37 54 CC 74 DC 0
5 3 01 00 37 54 44 74 54 0
# Mode update masks the upper read-back for one edge
6 3 C0 12 0F 96 00 FF 96 0
6 1 40 10 0F 3D 00 FF 0D 0
6 3 00 00 0F 3D 00 FF 3D 0
